// File: files.f
+incdir+rtl
rtl/pcxt_timing_pkg.sv
rtl/pcxt_ctrl_pkg.sv
rtl/input_synchronizer.sv
rtl/interval_timer.sv
rtl/reset_sequencer.sv
rtl/cen_fractional.sv
rtl/cpu_clock_select.sv
rtl/pcxt_clock_reset.sv
dv/tb_clock_gen.sv
dv/tb_pcxt_clock_reset.sv

// File: dv/tb_pcxt_clock_reset.sv
// PC/XT clock and reset testbench
`timescale 1ns/1ps
`include "pcxt_consts.svh"

module tb_pcxt_clock_reset;
	import pcxt_timing_pkg::*;
	import pcxt_ctrl_pkg::*;

	// Shortened splash and stretch
	localparam int tick_count   = 200;
	localparam int seconds      = 5;
	localparam int stretch      = 300;
	localparam int reset_cycles = 16;
	// Allowed lateness of the sys_reset fall
	localparam int fall_slack   = 8;
	localparam int ps2_steps    = 12;
	// Turbo and PS/2 phases of one row, rounded up
	localparam int phase_cycles = 64;
	localparam int row_count    = 5;

	// One row of stimulus
	typedef struct {
		string      name;
		logic       skip;
		cpu_speed_t speed;
		int         window;
		logic [7:0] biu_pattern;
	} row_t;

	logic       CLK_50M;
	logic       reset_wire;
	logic       skip_splash;
	cpu_speed_t speed_sel;
	logic       biu_done;
	ps2_lines_t ps2_in;
	logic       sys_reset;
	logic       cpu_reset;
	logic       splash_active;
	logic       cpu_ce;
	logic       peripheral_ce;
	logic       audio_ce;
	logic       turbo_mode;
	ps2_lines_t ps2_out;

	row_t        rows [row_count];
	int          error_count;
	int          cycle_count;
	int          limit_cycles;

	tb_clock_gen #(.period_ns(20.0)) u_clock_gen (.CLK_50M(CLK_50M));

	pcxt_clock_reset #(
		.splash_tick_count (tick_count),
		.splash_seconds    (seconds),
		.reset_stretch     (stretch)
	) uut (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.skip_splash   (skip_splash),
		.speed_sel     (speed_sel),
		.biu_done      (biu_done),
		.ps2_in        (ps2_in),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset),
		.splash_active (splash_active),
		.cpu_ce        (cpu_ce),
		.peripheral_ce (peripheral_ce),
		.audio_ce      (audio_ce),
		.turbo_mode    (turbo_mode),
		.ps2_out       (ps2_out)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reference rules

	// Reserved code runs at normal speed
	function automatic longint cpu_rate(input cpu_speed_t s);
		case (s)
			speed_7m16: return `PCXT_RATE_7M16;
			speed_14m3: return `PCXT_RATE_14M3;
			default:    return `PCXT_RATE_4M77;
		endcase
	endfunction

	// Strobes in n cycles at a given rate
	function automatic int strobe_count(input int n, input longint rate);
		return int'((longint'(n) * rate) / longint'(`PCXT_CLK_HZ));
	endfunction

	function automatic logic is_turbo(input cpu_speed_t s);
		return (s == speed_7m16) || (s == speed_14m3);
	endfunction

	// Flips turbo status of the code
	function automatic cpu_speed_t alt_speed(input cpu_speed_t s);
		return cpu_speed_t'(s ^ 2'b01);
	endfunction

	function automatic int run_limit();
		int total;
		int i;
		total = 0;
		for (i = 0; i < row_count; i++) begin
			total += rows[i].window + reset_cycles + phase_cycles;
			total += stretch + fall_slack + `PCXT_CPU_RESET_DELAY;
			if (!rows[i].skip) begin
				total += tick_count * seconds;
			end
		end
		return 2 * total;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic halt_on_error();
		error_count++;
		$display("STATUS: FAIL");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_level(input string test, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error %s expected %0b actual %0b", test, expected, actual);
			halt_on_error();
		end
	endtask

	task automatic check_count(input string test, input int expected, input int actual);
		if (actual != expected) begin
			$display("error %s expected %0d actual %0d", test, expected, actual);
			halt_on_error();
		end
	endtask

	task automatic check_speed(input string test, input cpu_speed_t expected,
			input cpu_speed_t actual);
		if (actual !== expected) begin
			$display("error %s expected %0d actual %0d", test, expected, actual);
			halt_on_error();
		end
	endtask

	task automatic check_ps2(input string test, input ps2_lines_t expected,
			input ps2_lines_t actual);
		if (actual !== expected) begin
			$display("error %s expected %b actual %b", test, expected, actual);
			halt_on_error();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table

	task automatic load_table();
		rows[0] = '{"splash_normal", 1'b0, speed_normal, 3000, 8'b0100_0010};
		rows[1] = '{"skip_7m16", 1'b1, speed_7m16, 2500, 8'b1001_0001};
		rows[2] = '{"skip_14m3", 1'b1, speed_14m3, 2000, 8'b0000_0000};
		rows[3] = '{"splash_reserved", 1'b0, speed_reserved, 3000, 8'b0110_0100};
		rows[4] = '{"skip_normal_long", 1'b1, speed_normal, 5000, 8'b1000_1000};
	endtask

	task automatic run_row(input row_t r);
		int         k;
		int         j;
		int         lo;
		int         splash_cycles;
		int         sys_fall;
		int         cpu_delay;
		int         n_cpu;
		int         n_per;
		int         n_aud;
		logic       turbo_exp;
		cpu_speed_t cur_speed;
		logic [31:0] rnd;
		ps2_lines_t sent[$];

		// Row inputs settle while reset is held
		@(posedge CLK_50M);
		reset_wire  <= 1'b1;
		skip_splash <= r.skip;
		speed_sel   <= r.speed;
		biu_done    <= 1'b0;
		repeat (reset_cycles) @(posedge CLK_50M);
		reset_wire <= 1'b0;

		// k counts edges since reset release
		k             = 0;
		splash_cycles = 0;
		sys_fall      = -1;
		while (sys_fall < 0) begin
			@(negedge CLK_50M);
			if (k == 0) begin
				check_ps2({r.name, " ps2 cleared"}, ps2_lines_t'(2'b00), ps2_out);
			end
			if (splash_active) begin
				splash_cycles++;
			end
			if (sys_reset) begin
				check_level({r.name, " strobes idle in reset"}, 1'b0,
					cpu_ce | peripheral_ce | audio_ce);
				check_level({r.name, " cpu_reset held"}, 1'b1, cpu_reset);
				k++;
			end else begin
				sys_fall = k;
			end
		end

		// Splash hold and stretch
		if (r.skip) begin
			lo = stretch;
		end else begin
			lo = tick_count * seconds + stretch;
			check_level({r.name, " splash held"}, 1'b1,
				splash_cycles >= tick_count * seconds);
		end
		check_level($sformatf("%s sys_reset fall in %0d..%0d", r.name, lo, lo + fall_slack),
			1'b1, (sys_fall >= lo) && (sys_fall <= lo + fall_slack));
		// Splash is over once the stretch has run
		check_level({r.name, " splash ended"}, 1'b0, splash_active);
		check_speed({r.name, " speed synchronized"}, r.speed, uut.speed_sync);

		// Strobe window from sys_reset fall
		n_cpu     = 0;
		n_per     = 0;
		n_aud     = 0;
		cpu_delay = -1;
		for (j = 1; j <= r.window; j++) begin
			@(negedge CLK_50M);
			if (cpu_ce) n_cpu++;
			if (peripheral_ce) n_per++;
			if (audio_ce) n_aud++;
			if ((cpu_delay < 0) && !cpu_reset) begin
				cpu_delay = j;
			end
		end
		check_count({r.name, " cpu_reset delay"}, `PCXT_CPU_RESET_DELAY, cpu_delay);
		check_count({r.name, " cpu_ce count"}, strobe_count(r.window, cpu_rate(r.speed)), n_cpu);
		check_count({r.name, " peripheral_ce count"},
			strobe_count(r.window, `PCXT_RATE_PERIPH), n_per);
		check_count({r.name, " audio_ce count"}, strobe_count(r.window, `PCXT_RATE_AUDIO), n_aud);
		// No biu_done yet
		check_level({r.name, " turbo before biu_done"}, 1'b0, turbo_mode);

		// Turbo latch, speed flips halfway
		turbo_exp = 1'b0;
		cur_speed = r.speed;
		for (j = 0; j < 8; j++) begin
			if (j == 4) begin
				cur_speed = alt_speed(cur_speed);
				@(posedge CLK_50M);
				speed_sel <= cur_speed;
				repeat (3) @(posedge CLK_50M);
				@(negedge CLK_50M);
				check_speed({r.name, " speed changed"}, cur_speed, uut.speed_sync);
			end
			@(posedge CLK_50M);
			biu_done <= r.biu_pattern[j];
			@(posedge CLK_50M);
			biu_done <= 1'b0;
			if (r.biu_pattern[j]) begin
				turbo_exp = is_turbo(cur_speed);
			end
			@(posedge CLK_50M);
			@(negedge CLK_50M);
			check_level($sformatf("%s turbo slot %0d", r.name, j), turbo_exp, turbo_mode);
		end

		// PS/2 lines, new value every cycle
		for (j = 0; j < ps2_steps; j++) begin
			@(posedge CLK_50M);
			rnd = $urandom();
			sent.push_back(ps2_lines_t'(rnd[1:0]));
			ps2_in <= sent[j];
			@(negedge CLK_50M);
			if (j >= 2) begin
				check_ps2($sformatf("%s ps2 step %0d", r.name, j), sent[j - 2], ps2_out);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Run control

	always @(posedge CLK_50M) begin
		cycle_count <= cycle_count + 1;
		if ((limit_cycles > 0) && (cycle_count >= limit_cycles)) begin
			$display("timeout after %0d cycles, sequence or strobe window never ended",
				cycle_count);
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	end

	initial begin
		int i;
		void'($urandom(32'hbe30ad8e));
		reset_wire    = 1'b1;
		skip_splash   = 1'b0;
		speed_sel     = speed_normal;
		biu_done      = 1'b0;
		ps2_in        = ps2_lines_t'(2'b00);
		error_count   = 0;
		cycle_count   = 0;
		load_table();
		limit_cycles  = run_limit();

		for (i = 0; i < row_count; i++) begin
			run_row(rows[i]);
		end

		if (error_count == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("STATUS: FAIL");
			$fatal(1, "checks failed");
		end
	end

endmodule

// File: dv/tb_clock_gen.sv
// Testbench clock source
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter real period_ns = 20.0
) (
	output logic CLK_50M
);

	// Free running, starts low
	initial begin
		CLK_50M = 1'b0;
		forever begin
			#(period_ns / 2.0) CLK_50M = ~CLK_50M;
		end
	end

endmodule

// File: rtl/pcxt_clock_reset.sv
// PC/XT clock and reset control
// Single clock, all rates as clock enables
`timescale 1ns/1ps
`include "pcxt_consts.svh"

module pcxt_clock_reset #(
	parameter int unsigned splash_tick_count = `PCXT_CLK_HZ,
	parameter int unsigned splash_seconds    = `PCXT_SPLASH_SECONDS_DEFAULT,
	parameter int unsigned reset_stretch     = `PCXT_RESET_STRETCH_DEFAULT
) (
	input  logic                        CLK_50M,
	input  logic                        reset_wire,
	input  logic                        skip_splash,
	input  pcxt_timing_pkg::cpu_speed_t speed_sel,
	input  logic                        biu_done,
	input  pcxt_ctrl_pkg::ps2_lines_t   ps2_in,
	output logic                        sys_reset,
	output logic                        cpu_reset,
	output logic                        splash_active,
	output logic                        cpu_ce,
	output logic                        peripheral_ce,
	output logic                        audio_ce,
	output logic                        turbo_mode,
	output pcxt_ctrl_pkg::ps2_lines_t   ps2_out
);
	import pcxt_timing_pkg::*;
	import pcxt_ctrl_pkg::*;

	cpu_speed_t speed_sync;
	logic       skip_sync;
	logic       timer_load;
	interval_t  timer_interval;
	logic       timer_expired;

	////////////////////////////////////////////////////////////////////////////
	// Input synchronizers

	// Keyboard clock and data
	input_synchronizer #(.payload_t(ps2_lines_t)) u_sync_ps2 (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.async_in   (ps2_in),
		.sync_out   (ps2_out)
	);

	input_synchronizer #(.payload_t(cpu_speed_t)) u_sync_speed (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.async_in   (speed_sel),
		.sync_out   (speed_sync)
	);

	input_synchronizer #(.payload_t(logic)) u_sync_skip (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.async_in   (skip_splash),
		.sync_out   (skip_sync)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reset sequence

	interval_timer u_interval_timer (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.load       (timer_load),
		.interval   (timer_interval),
		.expired    (timer_expired)
	);

	reset_sequencer #(
		.splash_tick_count (splash_tick_count),
		.splash_seconds    (splash_seconds),
		.reset_stretch     (reset_stretch)
	) u_reset_seq (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.skip_splash   (skip_sync),
		.expired       (timer_expired),
		.load          (timer_load),
		.interval      (timer_interval),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset),
		.splash_active (splash_active)
	);

	////////////////////////////////////////////////////////////////////////////
	// Clock enables, all idle during system reset

	// biu_done already in this clock domain
	cpu_clock_select u_cpu_clock (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.hold       (sys_reset),
		.speed      (speed_sync),
		.biu_done   (biu_done),
		.cpu_ce     (cpu_ce),
		.turbo_mode (turbo_mode)
	);

	cen_fractional #(.rate_hz(`PCXT_RATE_PERIPH)) u_cen_periph (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.hold       (sys_reset),
		.ce         (peripheral_ce)
	);

	// 44.1 kHz sample strobe
	cen_fractional #(.rate_hz(`PCXT_RATE_AUDIO)) u_cen_audio (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.hold       (sys_reset),
		.ce         (audio_ce)
	);

endmodule

// File: rtl/cpu_clock_select.sv
// CPU clock enable and turbo latch
// Selectable rate from a phase accumulator
`timescale 1ns/1ps
`include "pcxt_consts.svh"

module cpu_clock_select (
	input  logic                        CLK_50M,
	input  logic                        reset_wire,
	input  logic                        hold,
	input  pcxt_timing_pkg::cpu_speed_t speed,
	input  logic                        biu_done,
	output logic                        cpu_ce,
	output logic                        turbo_mode
);
	import pcxt_timing_pkg::*;

	// Wrap point of the accumulator
	localparam accum_t modulus = accum_t'(`PCXT_CLK_HZ);

	accum_t increment;
	accum_t accum;
	accum_t accum_next;
	logic   turbo_speed;

	////////////////////////////////////////////////////////////////////////////
	// Rate select

	always_comb begin
		case (speed)
			speed_7m16: increment = accum_t'(`PCXT_RATE_7M16);
			speed_14m3: increment = accum_t'(`PCXT_RATE_14M3);
			// Normal and reserved codes
			default:    increment = accum_t'(`PCXT_RATE_4M77);
		endcase
	end

	// Either fast code counts as turbo
	assign turbo_speed = (speed == speed_7m16) || (speed == speed_14m3);

	// New rate applies on the next add
	assign accum_next = accum + increment;

	////////////////////////////////////////////////////////////////////////////
	// Phase accumulator

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			accum  <= '0;
			cpu_ce <= 1'b0;
		end else if (hold) begin
			// Held in system reset
			accum  <= '0;
			cpu_ce <= 1'b0;
		end else if (accum_next >= modulus) begin
			accum  <= accum_next - modulus;
			cpu_ce <= 1'b1;
		end else begin
			accum  <= accum_next;
			cpu_ce <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Turbo flag

	// Only updated at a bus cycle boundary
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			turbo_mode <= 1'b0;
		end else if (biu_done) begin
			turbo_mode <= turbo_speed;
		end
	end

	// Turbo moves only right after biu_done
	a_turbo_on_done: assert property (
		@(posedge CLK_50M) disable iff (reset_wire)
		!$stable(turbo_mode) |-> $past(biu_done)
	) else $error("turbo_mode changed without biu_done");

endmodule

// File: rtl/cen_fractional.sv
// Fractional clock enable
`timescale 1ns/1ps
`include "pcxt_consts.svh"

module cen_fractional #(
	parameter int unsigned rate_hz = `PCXT_RATE_AUDIO
) (
	input  logic CLK_50M,
	input  logic reset_wire,
	input  logic hold,
	output logic ce
);
	import pcxt_timing_pkg::*;

	// Accumulator wraps at the system clock rate
	localparam accum_t modulus   = accum_t'(`PCXT_CLK_HZ);
	localparam accum_t increment = accum_t'(rate_hz);

	accum_t accum;
	accum_t accum_next;

	// One add per cycle
	assign accum_next = accum + increment;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			accum <= '0;
			ce    <= 1'b0;
		end else if (hold) begin
			// Phase restarts from zero on release
			accum <= '0;
			ce    <= 1'b0;
		end else if (accum_next >= modulus) begin
			// Wrap and strobe
			accum <= accum_next - modulus;
			ce    <= 1'b1;
		end else begin
			accum <= accum_next;
			ce    <= 1'b0;
		end
	end

	// No strobe while held
	a_idle_on_hold: assert property (
		@(posedge CLK_50M) disable iff (reset_wire)
		hold |-> !ce
	) else $error("cen_fractional strobe while hold high");

endmodule

// File: rtl/reset_sequencer.sv
// Reset sequencer
// Splash hold, reset stretch and CPU reset release
`timescale 1ns/1ps
`include "pcxt_consts.svh"

module reset_sequencer #(
	parameter int unsigned splash_tick_count = `PCXT_CLK_HZ,
	parameter int unsigned splash_seconds    = `PCXT_SPLASH_SECONDS_DEFAULT,
	parameter int unsigned reset_stretch     = `PCXT_RESET_STRETCH_DEFAULT
) (
	input  logic                     CLK_50M,
	input  logic                     reset_wire,
	input  logic                     skip_splash,
	input  logic                     expired,
	output logic                     load,
	output pcxt_ctrl_pkg::interval_t interval,
	output logic                     sys_reset,
	output logic                     cpu_reset,
	output logic                     splash_active
);
	import pcxt_ctrl_pkg::*;

	// Timer intervals per phase
	localparam interval_t tick_interval    = interval_t'(splash_tick_count);
	localparam interval_t stretch_interval = interval_t'(reset_stretch);
	localparam interval_t cpu_interval     = interval_t'(`PCXT_CPU_RESET_DELAY);
	// Seconds counter value on the final splash second
	localparam interval_t last_second      = interval_t'(splash_seconds - 1);

	reset_state_t state;
	// Splash seconds already elapsed
	interval_t    sec_cnt;
	// Low only in the first cycle after reset
	logic         started;

	logic skip_now;
	logic second_done;
	logic splash_done;

	////////////////////////////////////////////////////////////////////////////
	// Splash exit decode

	assign skip_now    = (state == st_splash) && skip_splash;
	assign second_done = (state == st_splash) && expired;
	// Exit on skip or when the last second runs out
	assign splash_done = skip_now || (second_done && (sec_cnt == last_second));

	////////////////////////////////////////////////////////////////////////////
	// Timer load on entry to each phase

	always_comb begin
		load     = 1'b0;
		interval = tick_interval;
		case (state)
			st_splash: begin
				if (splash_done) begin
					// Start of stretch
					load     = 1'b1;
					interval = stretch_interval;
				end else if (!started || second_done) begin
					// Next splash second
					load = 1'b1;
				end
			end
			st_stretch: begin
				// Stretch done, start CPU delay
				load     = expired;
				interval = cpu_interval;
			end
			default: begin
				// No timer in use
				load = 1'b0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// State register and reset outputs

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			state         <= st_splash;
			sec_cnt       <= '0;
			started       <= 1'b0;
			sys_reset     <= 1'b1;
			cpu_reset     <= 1'b1;
			splash_active <= 1'b1;
		end else begin
			started <= 1'b1;
			case (state)
				st_splash: begin
					if (splash_done) begin
						state         <= st_stretch;
						splash_active <= 1'b0;
					end else if (second_done) begin
						sec_cnt <= sec_cnt + interval_t'(1);
					end
				end
				st_stretch: begin
					// System leaves reset here
					if (expired) begin
						state     <= st_cpu_wait;
						sys_reset <= 1'b0;
					end
				end
				st_cpu_wait: begin
					// CPU follows after fixed delay
					if (expired) begin
						state     <= st_run;
						cpu_reset <= 1'b0;
					end
				end
				default: begin
					state <= st_run;
				end
			endcase
		end
	end

	// CPU never runs while the system is held
	a_cpu_after_sys: assert property (
		@(posedge CLK_50M) disable iff (reset_wire)
		sys_reset |-> cpu_reset
	) else $error("cpu_reset released while sys_reset high");

endmodule

// File: rtl/interval_timer.sv
// Loadable interval timer
`timescale 1ns/1ps

module interval_timer (
	input  logic                     CLK_50M,
	input  logic                     reset_wire,
	input  logic                     load,
	input  pcxt_ctrl_pkg::interval_t interval,
	output logic                     expired
);
	import pcxt_ctrl_pkg::*;

	// Cycles left before expiry minus one
	// Zero means idle
	interval_t count;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			count   <= '0;
			expired <= 1'b0;
		end else if (load) begin
			// New load restarts the count
			count   <= (interval > interval_t'(1)) ? interval - interval_t'(1) : '0;
			// Interval of one fires on the very next cycle
			expired <= (interval == interval_t'(1));
		end else if (count != '0) begin
			count   <= count - interval_t'(1);
			expired <= (count == interval_t'(1));
		end else begin
			// Idle until next load
			expired <= 1'b0;
		end
	end

	// Single pulse per interval
	a_expired_single: assert property (
		@(posedge CLK_50M) disable iff (reset_wire)
		expired |=> !expired
	) else $error("interval_timer expired held for two cycles");

endmodule

// File: rtl/input_synchronizer.sv
// Two-flop input synchronizer
`timescale 1ns/1ps

module input_synchronizer #(
	parameter type payload_t = logic
) (
	input  logic     CLK_50M,
	input  logic     reset_wire,
	input  payload_t async_in,
	output payload_t sync_out
);

	// First stage
	// May go metastable, never read outside
	payload_t meta;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			// Both stages idle at zero
			meta     <= payload_t'('0);
			sync_out <= payload_t'('0);
		end else begin
			meta     <= async_in;
			// Second stage settles the value
			sync_out <= meta;
		end
	end

endmodule

// File: rtl/pcxt_ctrl_pkg.sv
// Reset control types
// Sequencer states and synchronized inputs

package pcxt_ctrl_pkg;

	// Reset sequencer states in order of progress
	typedef enum logic [1:0] {
		st_splash   = 2'd0,
		st_stretch  = 2'd1,
		st_cpu_wait = 2'd2,
		st_run      = 2'd3
	} reset_state_t;

	// Interval timer count
	typedef logic [31:0] interval_t;

	// Keyboard lines
	typedef struct packed {
		logic ps2_clk;
		logic ps2_data;
	} ps2_lines_t;

endpackage

// File: rtl/pcxt_timing_pkg.sv
// Clock enable timing types
// Accumulator word and CPU speed code

package pcxt_timing_pkg;

	// Phase accumulator word
	// Sum of accumulator and largest increment stays below 2^32
	typedef logic [31:0] accum_t;

	// CPU speed code
	// Reserved code runs at normal speed
	typedef enum logic [1:0] {
		speed_normal   = 2'd0,
		speed_7m16     = 2'd1,
		speed_14m3     = 2'd2,
		speed_reserved = 2'd3
	} cpu_speed_t;

endpackage

// File: rtl/pcxt_consts.svh
// PC/XT clock and reset constants
`ifndef PCXT_CONSTS_SVH
`define PCXT_CONSTS_SVH

// System clock in Hz
// Also the modulus of every phase accumulator
`define PCXT_CLK_HZ 50000000

// CPU rates derived from the 14.318 MHz crystal
// Normal speed is crystal / 3
`define PCXT_RATE_4M77 4772727
// Crystal / 2
`define PCXT_RATE_7M16 7159090
// Full crystal rate
`define PCXT_RATE_14M3 14318180

// Peripheral rate at half the normal CPU rate
`define PCXT_RATE_PERIPH 2386363

// Audio sample strobe
`define PCXT_RATE_AUDIO 44100

// Cycles from sys_reset fall to cpu_reset fall
`define PCXT_CPU_RESET_DELAY 43

// Power-on reset stretch in cycles
`define PCXT_RESET_STRETCH_DEFAULT 65535

// Splash screen hold in seconds
`define PCXT_SPLASH_SECONDS_DEFAULT 5

`endif
